/* tb.f */
+incdir+logic
logic/dso_pkg.sv
logic/dds_gen.sv
logic/pulse_gen.sv
logic/param_measure.sv
logic/dso_top.sv
testbench/dso_assertions.sv
testbench/tb_dso_top.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_dso_top -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_dso_top

clean:
	rm -rf obj_dir

/* testbench/tb_dso_top.sv */
`timescale 1ns/100ps
module tb_dso_top
  import dso_pkg::*;
;

  localparam int RESET_CYCLES = 16;
  localparam int N_ROWS = 9;
  // each row spends up to three gates, plus the gate after reset and margin
  localparam int TIMEOUT_CYCLES = (N_ROWS * 3 + 2) * GATE_CYCLES + RESET_CYCLES;

  // stimulus table, one column per array
  localparam logic [1:0] ROW_WAVE [N_ROWS] = '{WAVE_SAW, WAVE_SAW, WAVE_SAW,
    WAVE_TRIANGLE, WAVE_TRIANGLE, WAVE_SQUARE, WAVE_SINE, WAVE_SINE, WAVE_TRIANGLE};
  // periods per gate
  localparam int ROW_K [N_ROWS] = '{1, 4, 16, 2, 8, 4, 1, 16, 2};
  // 0 means level drawn from the lfsr
  localparam int ROW_TRIG [N_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 255};
  localparam int ROW_FREQ [N_ROWS] = '{1, 4, 16, 2, 8, 4, 1, 16, 0};
  localparam int ROW_MAX [N_ROWS] = '{255, 255, 255, 254, 254, 255, 255, 255, 254};
  localparam int ROW_MIN [N_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0};

  logic                ad_clk;
  logic                sys_rst_n;
  logic                wave_load;
  logic [1:0]          wave_sel;
  logic [PHASE_W-1:0]  freq_word;
  logic [7:0]          trig_level;
  // loopback register, dac back into adc
  logic [SAMPLE_W-1:0] ad_data = '0;
  logic [SAMPLE_W-1:0] dac_data;
  logic                ad_pulse;
  logic                meas_valid;
  logic [FREQ_W-1:0]   ad_freq;
  logic [SAMPLE_W-1:0] ad_max;
  logic [SAMPLE_W-1:0] ad_min;
  logic [SAMPLE_W-1:0] ad_vpp;
  logic [31:0]         lfsr;
  int                  cycle_cnt = 0;

  dso_top UUT (
    .ad_clk     (ad_clk),
    .sys_rst_n  (sys_rst_n),
    .wave_load  (wave_load),
    .wave_sel   (wave_sel),
    .freq_word  (freq_word),
    .trig_level (trig_level),
    .ad_data    (ad_data),
    .dac_data   (dac_data),
    .ad_pulse   (ad_pulse),
    .meas_valid (meas_valid),
    .ad_freq    (ad_freq),
    .ad_max     (ad_max),
    .ad_min     (ad_min),
    .ad_vpp     (ad_vpp)
  );

  initial begin
    ad_clk = 1'b0;
    forever #5 ad_clk = ~ad_clk;
  end

  // one cycle of adc latency
  always @(posedge ad_clk)
    ad_data <= #1 dac_data;

  // run length guard
  always @(posedge ad_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("RESULT: FAIL");
      $fatal(1, "timeout: no final result after %0d clock cycles", TIMEOUT_CYCLES);
    end
  end

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // eight lfsr steps, scaled into 32 .. 223
  task automatic random_level(output logic [7:0] level);
    logic [7:0] bits;
    bits = '0;
    for (int b = 0; b < 8; b++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[6:0], lfsr[0]};
    end
    level = 8'(32 + (int'(bits) * 3) / 4);
  endtask

  // clock edges until meas_valid shows up
  task automatic wait_valid(output int cycles);
    cycles = 0;
    do begin
      @(posedge ad_clk);
      #1;
      cycles++;
    end while (!meas_valid);
  endtask

  initial begin
    int         n;
    logic [7:0] level;
    sys_rst_n  = 1'b0;
    wave_load  = 1'b0;
    wave_sel   = WAVE_SINE;
    freq_word  = '0;
    trig_level = 8'd128;
    lfsr       = 32'he78;
    // outputs idle through reset
    repeat (RESET_CYCLES) begin
      @(posedge ad_clk);
      #1;
      check_value("meas_valid in reset", 32'(meas_valid), 0);
      check_value("ad_pulse in reset", 32'(ad_pulse), 0);
      check_value("dac_data in reset", 32'(dac_data), 0);
    end
    sys_rst_n = 1'b1;
    // first strobe only after a whole gate
    wait_valid(n);
    check_value("cycles from reset to meas_valid", 32'(n), GATE_CYCLES);
    for (int r = 0; r < N_ROWS; r++) begin
      if (ROW_TRIG[r] == 0)
        random_level(level);
      else
        level = 8'(ROW_TRIG[r]);
      wave_sel   = ROW_WAVE[r];
      // k periods in exactly one gate
      freq_word  = PHASE_W'(ROW_K[r]) << 20;
      trig_level = level;
      wave_load  = 1'b1;
      @(posedge ad_clk);
      #1;
      wave_load = 1'b0;
      wait_valid(n);
      check_value("cycles from load to meas_valid", 32'(n), GATE_CYCLES);
      // first window holds stale loopback data
      wait_valid(n);
      check_value("cycles between meas_valid", 32'(n), GATE_CYCLES);
      check_value("ad_freq", 32'(ad_freq), ROW_FREQ[r]);
      check_value("ad_max", 32'(ad_max), ROW_MAX[r]);
      check_value("ad_min", 32'(ad_min), ROW_MIN[r]);
      check_value("ad_vpp", 32'(ad_vpp), ROW_MAX[r] - ROW_MIN[r]);
    end
    if (UUT.param_measure_inst.meas_chk.fail_cnt == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "bound assertions on param_measure failed");
    end
  end

endmodule

/* testbench/dso_assertions.sv */
`timescale 1ns/100ps
module param_measure_assertions
  import dso_pkg::*;
(
  input logic                ad_clk,
  input logic                sys_rst_n,
  input logic                meas_valid,
  input logic [SAMPLE_W-1:0] ad_max,
  input logic [SAMPLE_W-1:0] ad_min,
  input logic [SAMPLE_W-1:0] ad_vpp
);

  // assertion failures so far
  int fail_cnt = 0;

  // result strobe lasts one cycle
  valid_single: assert property (@(posedge ad_clk) disable iff (!sys_rst_n)
    meas_valid |=> !meas_valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("meas_valid stayed high for two cycles");
    end

  // peak-to-peak matches the extremes
  vpp_match: assert property (@(posedge ad_clk) disable iff (!sys_rst_n)
    meas_valid |-> (ad_vpp == SAMPLE_W'(ad_max - ad_min)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ad_vpp differs from ad_max minus ad_min");
    end

  // extremes ordered
  max_above_min: assert property (@(posedge ad_clk) disable iff (!sys_rst_n)
    meas_valid |-> (ad_max >= ad_min))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ad_max below ad_min");
    end

endmodule

bind param_measure param_measure_assertions meas_chk (
  .ad_clk     (ad_clk),
  .sys_rst_n  (sys_rst_n),
  .meas_valid (meas_valid),
  .ad_max     (ad_max),
  .ad_min     (ad_min),
  .ad_vpp     (ad_vpp)
);

/* logic/dso_top.sv */
`timescale 1ns/100ps
module dso_top
  import dso_pkg::*;
(
  input  logic                ad_clk,
  input  logic                sys_rst_n,
  input  logic                wave_load,
  input  logic [1:0]          wave_sel,
  input  logic [PHASE_W-1:0]  freq_word,
  input  logic [7:0]          trig_level,
  input  logic [SAMPLE_W-1:0] ad_data,
  output logic [SAMPLE_W-1:0] dac_data,
  output logic                ad_pulse,
  output logic                meas_valid,
  output logic [FREQ_W-1:0]   ad_freq,
  output logic [SAMPLE_W-1:0] ad_max,
  output logic [SAMPLE_W-1:0] ad_min,
  output logic [SAMPLE_W-1:0] ad_vpp
);

  // waveform generator
  dds_gen dds_gen_inst (
    .ad_clk    (ad_clk),
    .sys_rst_n (sys_rst_n),
    .wave_load (wave_load),
    .wave_sel  (wave_sel),
    .freq_word (freq_word),
    .dac_data  (dac_data)
  );

  // trigger comparator on the adc stream
  pulse_gen pulse_gen_inst (
    .ad_clk     (ad_clk),
    .sys_rst_n  (sys_rst_n),
    .ad_data    (ad_data),
    .trig_level (trig_level),
    .ad_pulse   (ad_pulse)
  );

  // a new waveform also restarts the gate
  param_measure param_measure_inst (
    .ad_clk       (ad_clk),
    .sys_rst_n    (sys_rst_n),
    .gate_restart (wave_load),
    .ad_data      (ad_data),
    .ad_pulse     (ad_pulse),
    .meas_valid   (meas_valid),
    .ad_freq      (ad_freq),
    .ad_max       (ad_max),
    .ad_min       (ad_min),
    .ad_vpp       (ad_vpp)
  );

endmodule

/* logic/param_measure.sv */
`timescale 1ns/100ps
module param_measure
  import dso_pkg::*;
(
  input  logic                ad_clk,
  input  logic                sys_rst_n,
  input  logic                gate_restart,
  input  logic [SAMPLE_W-1:0] ad_data,
  input  logic                ad_pulse,
  output logic                meas_valid,
  output logic [FREQ_W-1:0]   ad_freq,
  output logic [SAMPLE_W-1:0] ad_max,
  output logic [SAMPLE_W-1:0] ad_min,
  output logic [SAMPLE_W-1:0] ad_vpp
);

  // gate window position
  logic [GATE_W-1:0]   gate_cnt;
  logic                gate_first;
  logic                gate_last;
  // trigger edge detect
  logic                pulse_d;
  logic                pulse_rise;
  // running window state
  logic [FREQ_W-1:0]   edge_cnt;
  logic [FREQ_W-1:0]   edge_next;
  logic [SAMPLE_W-1:0] run_max;
  logic [SAMPLE_W-1:0] run_min;
  logic [SAMPLE_W-1:0] max_next;
  logic [SAMPLE_W-1:0] min_next;

  assign gate_first = (gate_cnt == '0);
  // a restart on the last cycle throws the window away
  assign gate_last  = (gate_cnt == GATE_W'(GATE_CYCLES - 1)) && !gate_restart;
  assign pulse_rise = ad_pulse && !pulse_d;

  // values including the current sample
  // first cycle of a window seeds from scratch
  assign edge_next = (gate_first ? '0 : edge_cnt) + FREQ_W'(pulse_rise);
  assign max_next  = (gate_first || (ad_data > run_max)) ? ad_data : run_max;
  assign min_next  = (gate_first || (ad_data < run_min)) ? ad_data : run_min;

  // gate counter, modulo GATE_CYCLES
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n)
      gate_cnt <= '0;
    else if (gate_restart || gate_last)
      gate_cnt <= '0;
    else
      gate_cnt <= gate_cnt + 1'b1;
  end

  // edge counting
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      pulse_d  <= 1'b0;
      edge_cnt <= '0;
    end else begin
      pulse_d  <= ad_pulse;
      edge_cnt <= edge_next;
    end
  end

  // extremes are reseeded each window
  always_ff @(posedge ad_clk) begin
    run_max <= max_next;
    run_min <= min_next;
  end

  // results latched on the last gate cycle
  // held until the next window ends
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      meas_valid <= 1'b0;
      ad_freq    <= '0;
      ad_max     <= '0;
      ad_min     <= '0;
      ad_vpp     <= '0;
    end else begin
      meas_valid <= gate_last;
      if (gate_last) begin
        ad_freq <= edge_next;
        ad_max  <= max_next;
        ad_min  <= min_next;
        // max never below min within one window
        ad_vpp  <= max_next - min_next;
      end
    end
  end

endmodule

/* logic/pulse_gen.sv */
`timescale 1ns/100ps
module pulse_gen
  import dso_pkg::*;
(
  input  logic                ad_clk,
  input  logic                sys_rst_n,
  input  logic [SAMPLE_W-1:0] ad_data,
  input  logic [7:0]          trig_level,
  output logic                ad_pulse
);

  // lower threshold for re-arming
  logic [SAMPLE_W-1:0] low_level;
  // low threshold exists only above the hysteresis band
  logic                hyst_ok;

  assign low_level = trig_level - SAMPLE_W'(TRIG_HYST);
  assign hyst_ok   = trig_level >= SAMPLE_W'(TRIG_HYST);

  // pulse low means armed
  // set on reaching the level, clear well below it
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      ad_pulse <= 1'b0;
    end else if (!ad_pulse) begin
      if (ad_data >= trig_level)
        ad_pulse <= 1'b1;
    end else begin
      // noise near trig_level cannot clear it
      if (hyst_ok && (ad_data < low_level))
        ad_pulse <= 1'b0;
    end
  end

endmodule

/* logic/dds_gen.sv */
`timescale 1ns/100ps
module dds_gen
  import dso_pkg::*;
(
  input  logic                ad_clk,
  input  logic                sys_rst_n,
  input  logic                wave_load,
  input  logic [1:0]          wave_sel,
  input  logic [PHASE_W-1:0]  freq_word,
  output logic [SAMPLE_W-1:0] dac_data
);

  // loaded settings
  logic [1:0]          wave_reg;
  logic [PHASE_W-1:0]  freq_reg;
  // accumulator and shaping
  logic [PHASE_W-1:0]  phase;
  logic [SAMPLE_W-1:0] p;
  logic [5:0]          idx;
  logic [6:0]          q;
  logic [SAMPLE_W-1:0] shaped;

  `include "sine_table.svh"

  // load restarts the phase at zero
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wave_reg <= WAVE_SINE;
      freq_reg <= '0;
      phase    <= '0;
    end else if (wave_load) begin
      wave_reg <= wave_sel;
      freq_reg <= freq_word;
      phase    <= '0;
    end else begin
      phase <= phase + freq_reg;
    end
  end

  // top bits of phase drive the lookup
  assign p = phase[PHASE_W-1 -: SAMPLE_W];

  always_comb begin
    // odd quarters walk the table backwards
    idx = p[6] ? ~p[5:0] : p[5:0];
    q   = SINE_QTR[idx];
    case (wave_reg)
      // 128+q on first half, 127-q on second
      WAVE_SINE:     shaped = p[7] ? {1'b0, ~q} : {1'b1, q};
      WAVE_SQUARE:   shaped = phase[PHASE_W-1] ? '0 : '1;
      // 2p rising then 2*(255-p) falling
      WAVE_TRIANGLE: shaped = p[7] ? {~p[6:0], 1'b0} : {p[6:0], 1'b0};
      WAVE_SAW:      shaped = p;
      default:       shaped = p;
    endcase
  end

  // registered dac sample
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n)
      dac_data <= '0;
    else
      dac_data <= shaped;
  end

endmodule

/* logic/dso_pkg.sv */
package dso_pkg;

  // sample width shared by adc and dac
  localparam int SAMPLE_W = 8;

  // phase accumulator width
  localparam int PHASE_W = 32;

  // edge count result width
  localparam int FREQ_W = 20;

  // waveform select codes
  localparam logic [1:0] WAVE_SINE     = 2'd0;
  localparam logic [1:0] WAVE_SQUARE   = 2'd1;
  localparam logic [1:0] WAVE_TRIANGLE = 2'd2;
  localparam logic [1:0] WAVE_SAW      = 2'd3;

  // measurement window in ad_clk cycles
  localparam int GATE_CYCLES = 4096;
  // wide enough for 0 .. GATE_CYCLES-1
  localparam int GATE_W = 12;

  // re-arm distance below trig_level
  localparam int TRIG_HYST = 16;

endpackage

/* logic/sine_table.svh */
`ifndef SINE_TABLE_SVH
`define SINE_TABLE_SVH

// first quarter of a sine, 127 * sin of the mid-point of each step
// 64 steps span 0 to 90 degrees
// mirrored and offset around 128 by the user
localparam logic [6:0] SINE_QTR [0:63] = '{
  7'd2,
  7'd5,
  7'd8,
  7'd11,
  7'd14,
  7'd17,
  7'd20,
  7'd23,
  7'd26,
  7'd29,
  7'd32,
  7'd35,
  7'd38,
  7'd41,
  7'd44,
  7'd47,
  7'd50,
  7'd53,
  7'd56,
  7'd58,
  7'd61,
  7'd64,
  7'd67,
  7'd69,
  7'd72,
  7'd74,
  7'd77,
  7'd79,
  7'd82,
  7'd84,
  7'd86,
  7'd89,
  7'd91,
  7'd93,
  7'd95,
  7'd97,
  7'd99,
  7'd101,
  7'd103,
  7'd105,
  7'd106,
  7'd108,
  7'd110,
  7'd111,
  7'd113,
  7'd114,
  7'd115,
  7'd117,
  7'd118,
  7'd119,
  7'd120,
  7'd121,
  7'd122,
  7'd123,
  7'd124,
  7'd124,
  7'd125,
  7'd125,
  7'd126,
  7'd126,
  7'd127,
  7'd127,
  7'd127,
  7'd127
};

`endif
